//--- verilog/pmu_defines.svh
`ifndef PMU_DEFINES_SVH
`define PMU_DEFINES_SVH

// Frame addresses and the parameter byte that selects the voltage path
`define SET_FRAME_ADDR   8'h70
`define QUERY_FRAME_ADDR 8'h50
`define PARAM_VOLT       8'h76

// PMU target on the I2C bus
`define PMU_ADDR_WR 8'h68
`define PMU_ADDR_RD 8'h69

`define SUB_ENABLE 8'h10
`define SUB_SLEW   8'h20
`define SUB_VOLT0  8'h32
`define SUB_VOLT1  8'h26
`define SUB_VOLT2  8'h29
`define SLEW_VALUE 8'h55

`define RESP_ACK 8'h06
`define RESP_NAK 8'h15

// clk cycles per quarter of an I2C bit
`define I2C_QUARTER 4

`endif

//--- verilog/pmu_pkg.sv
package pmu_pkg;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       frame;
	} in_byte_t;

	typedef struct packed {
		logic       query;
		logic       volt;
		logic [3:0] idx;
		logic [7:0] value;
	} pmu_cmd_t;

	typedef enum logic [1:0] {
		op_start,
		op_write,
		op_read,
		op_stop
	} i2c_op_t;

	typedef struct packed {
		i2c_op_t    op;
		logic [7:0] data;
	} i2c_req_t;

	typedef struct packed {
		logic       nak;
		logic       has_data;
		logic [7:0] data;
	} resp_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       last;
	} out_byte_t;

endpackage

//--- verilog/frame_decoder.sv
`include "pmu_defines.svh"

module frame_decoder (
	input  logic               clk,
	input  logic               reset,
	input  pmu_pkg::in_byte_t  in_byte,
	output pmu_pkg::pmu_cmd_t  cmd,
	output logic               cmd_valid,
	input  logic               cmd_take
);

	logic [2:0] count;
	logic       is_set;
	logic       is_query;
	logic       capture;

	// A frame whose first byte arrives while a command is pending is skipped whole
	assign capture = in_byte.frame && in_byte.valid && !cmd_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			is_set <= 1'b0;
			is_query <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			if (cmd_take)
				cmd_valid <= 1'b0;
			if (!in_byte.frame) begin
				count <= '0;
			end else if (in_byte.valid) begin
				if (count != 3'd4)
					count <= count + 3'd1;
				if (count == 3'd0) begin
					is_set <= !cmd_valid && (in_byte.data == `SET_FRAME_ADDR);
					is_query <= !cmd_valid && (in_byte.data == `QUERY_FRAME_ADDR);
				end
				if (capture && count == 3'd2 && is_query)
					cmd_valid <= 1'b1;
				if (capture && count == 3'd3 && is_set)
					cmd_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			case (count)
				3'd0: cmd.query <= (in_byte.data == `QUERY_FRAME_ADDR);
				3'd1: cmd.volt <= (in_byte.data == `PARAM_VOLT);
				3'd2: cmd.idx <= in_byte.data[3:0];
				3'd3: cmd.value <= in_byte.data;
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/i2c_bit_timer.sv
`include "pmu_defines.svh"

module i2c_bit_timer (
	input  logic clk,
	input  logic reset,
	input  logic run,
	output logic tick
);

	localparam int W = $clog2(`I2C_QUARTER) + 1;
	localparam logic [W-1:0] RELOAD = W'(`I2C_QUARTER - 1);

	logic [W-1:0] count;

	// Held at the reload value while idle so the first tick lands a fixed
	// number of cycles after run rises
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= RELOAD;
		end else if (!run || count == '0) begin
			count <= RELOAD;
		end else begin
			count <= count - W'(1);
		end
	end

	assign tick = run && (count == '0);

endmodule

//--- verilog/i2c_byte_engine.sv
module i2c_byte_engine (
	input  logic               clk,
	input  logic               reset,
	input  pmu_pkg::i2c_req_t  req,
	input  logic               req_valid,
	output logic               req_done,
	output logic               ack_ok,
	output logic [7:0]         rd_data,
	output logic               scl_low,
	output logic               sda_low,
	input  logic               sda_in,
	output logic               timer_run,
	input  logic               tick
);

	logic       active;
	logic [1:0] phase;
	logic [3:0] bit_cnt;
	logic [7:0] shift;
	logic       is_write;
	logic       last_tick;

	assign is_write = (req.op == pmu_pkg::op_write);
	assign timer_run = active;

	// Start and stop take one bit time, a byte takes nine including the ACK slot
	always_comb begin
		last_tick = 1'b0;
		if (tick && phase == 2'd3) begin
			if (req.op == pmu_pkg::op_start || req.op == pmu_pkg::op_stop)
				last_tick = 1'b1;
			else
				last_tick = (bit_cnt == 4'd8);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			phase <= '0;
			bit_cnt <= '0;
			scl_low <= 1'b0;
			sda_low <= 1'b0;
			ack_ok <= 1'b0;
			req_done <= 1'b0;
		end else begin
			req_done <= 1'b0;
			if (!active) begin
				if (req_valid && !req_done) begin
					active <= 1'b1;
					phase <= '0;
					bit_cnt <= '0;
				end
			end else if (tick) begin
				phase <= phase + 2'd1;
				case (req.op)
					pmu_pkg::op_start: begin
						if (phase == 2'd0) begin
							scl_low <= 1'b0;
							sda_low <= 1'b0;
						end
						if (phase == 2'd1)
							sda_low <= 1'b1;
						if (phase == 2'd3)
							scl_low <= 1'b1;
					end
					pmu_pkg::op_stop: begin
						if (phase == 2'd0) begin
							scl_low <= 1'b1;
							sda_low <= 1'b1;
						end
						if (phase == 2'd1)
							scl_low <= 1'b0;
						if (phase == 2'd2)
							sda_low <= 1'b0;
					end
					default: begin
						case (phase)
							2'd0: begin
								scl_low <= 1'b1;
								sda_low <= is_write && bit_cnt != 4'd8 && !shift[7];
							end
							2'd1: scl_low <= 1'b0;
							2'd2: begin
								if (bit_cnt == 4'd8)
									ack_ok <= !sda_in;
							end
							default: begin
								scl_low <= 1'b1;
								bit_cnt <= bit_cnt + 4'd1;
							end
						endcase
					end
				endcase
				if (last_tick) begin
					active <= 1'b0;
					req_done <= 1'b1;
				end
			end
		end
	end

	// Sampling at mid-high also moves the next write bit into the MSB
	always_ff @(posedge clk) begin
		if (!active && req_valid && !req_done)
			shift <= req.data;
		else if (active && tick && phase == 2'd2 && bit_cnt != 4'd8)
			shift <= {shift[6:0], sda_in};
	end

	assign rd_data = shift;

endmodule

//--- verilog/pmu_ctrl_fsm.sv
`include "pmu_defines.svh"

module pmu_ctrl_fsm (
	input  logic                clk,
	input  logic                reset,
	input  pmu_pkg::pmu_cmd_t   cmd,
	input  logic                cmd_valid,
	output logic                cmd_take,
	output pmu_pkg::i2c_req_t   req,
	output logic                req_valid,
	input  logic                req_done,
	input  logic                ack_ok,
	input  logic [7:0]          rd_data,
	output pmu_pkg::resp_req_t  resp,
	output logic                resp_valid,
	input  logic                resp_take
);

	typedef enum logic [3:0] {
		S_IDLE, S_W_START, S_W_ADDR, S_W_SUB, S_W_DATA, S_W_STOP,
		S_R_START, S_R_ADDR, S_R_READ, S_R_STOP, S_RESPOND
	} state_t;

	state_t            state;
	pmu_pkg::pmu_cmd_t cur;
	logic              slew;
	logic              fail;
	logic [2:0]        en_shadow;
	logic [4:0]        dac;
	logic [7:0]        rd_byte;
	logic [7:0]        subaddr;
	logic [7:0]        wr_value;
	logic [7:0]        result;

	assign cmd_take = (state == S_IDLE) && cmd_valid;

	always_comb begin
		if (slew)
			subaddr = `SUB_SLEW;
		else if (!cur.volt)
			subaddr = `SUB_ENABLE;
		else if (cur.idx == 4'd0)
			subaddr = `SUB_VOLT0;
		else if (cur.idx == 4'd1)
			subaddr = `SUB_VOLT1;
		else
			subaddr = `SUB_VOLT2;

		if (slew)
			wr_value = `SLEW_VALUE;
		else if (!cur.volt)
			wr_value = {3'b100, en_shadow[0], 1'b1, en_shadow[2:1], 1'b1};
		else
			wr_value = {3'b000, dac};
	end

	always_comb begin
		req.op = pmu_pkg::op_start;
		req.data = '0;
		req_valid = 1'b1;
		case (state)
			S_W_START, S_R_START: req.op = pmu_pkg::op_start;
			S_W_ADDR: begin
				req.op = pmu_pkg::op_write;
				req.data = `PMU_ADDR_WR;
			end
			S_W_SUB: begin
				req.op = pmu_pkg::op_write;
				req.data = subaddr;
			end
			S_W_DATA: begin
				req.op = pmu_pkg::op_write;
				req.data = wr_value;
			end
			S_R_ADDR: begin
				req.op = pmu_pkg::op_write;
				req.data = `PMU_ADDR_RD;
			end
			S_R_READ: req.op = pmu_pkg::op_read;
			S_W_STOP, S_R_STOP: req.op = pmu_pkg::op_stop;
			default: req_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			slew <= 1'b0;
			fail <= 1'b0;
			en_shadow <= '0;
		end else begin
			if (req_done && req.op == pmu_pkg::op_write)
				fail <= fail | !ack_ok;
			case (state)
				S_IDLE: begin
					if (cmd_valid) begin
						slew <= 1'b0;
						fail <= 1'b0;
						if (!cmd.query && !cmd.volt && cmd.idx < 4'd3)
							en_shadow[cmd.idx[1:0]] <= cmd.value[0];
						state <= S_W_START;
					end
				end
				S_RESPOND: if (resp_take) state <= S_IDLE;
				default: begin
					if (req_done) begin
						case (state)
							S_W_START: state <= S_W_ADDR;
							S_W_ADDR: state <= S_W_SUB;
							S_W_SUB: state <= cur.query ? S_W_STOP : S_W_DATA;
							S_W_DATA: state <= S_W_STOP;
							S_W_STOP: begin
								if (cur.query) begin
									state <= S_R_START;
								end else if (slew) begin
									state <= S_RESPOND;
								end else begin
									slew <= 1'b1;
									state <= S_W_START;
								end
							end
							S_R_START: state <= S_R_ADDR;
							S_R_ADDR: state <= S_R_READ;
							S_R_READ: state <= S_R_STOP;
							default: state <= S_RESPOND;
						endcase
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			cur <= cmd;
			if (!cmd.query && cmd.volt)
				dac <= cmd.value[4:0];
		end
		if (req_done && state == S_R_READ)
			rd_byte <= rd_data;
	end

	// Enable state of one rail sits at bit 4, 1 or 2 of the enable register
	always_comb begin
		if (cur.volt)
			result = rd_byte;
		else if (cur.idx == 4'd0)
			result = {7'd0, rd_byte[4]};
		else if (cur.idx == 4'd1)
			result = {7'd0, rd_byte[1]};
		else
			result = {7'd0, rd_byte[2]};
	end

	assign resp_valid = (state == S_RESPOND);
	assign resp.nak = fail;
	assign resp.has_data = cur.query && !fail;
	assign resp.data = result;

endmodule

//--- verilog/ack_frame_gen.sv
`include "pmu_defines.svh"

module ack_frame_gen (
	input  logic                clk,
	input  logic                reset,
	input  pmu_pkg::resp_req_t  resp,
	input  logic                resp_valid,
	output logic                resp_take,
	output pmu_pkg::out_byte_t  out,
	input  logic                out_ready
);

	logic data_phase;
	logic xfer;

	// The request stays put until resp_take, so the byte is held under back-pressure
	assign out.valid = resp_valid;
	assign out.data = data_phase ? resp.data : (resp.nak ? `RESP_NAK : `RESP_ACK);
	assign out.last = data_phase || resp.nak || !resp.has_data;

	assign xfer = out.valid && out_ready;
	assign resp_take = xfer && out.last;

	always_ff @(posedge clk) begin
		if (reset) begin
			data_phase <= 1'b0;
		end else if (xfer) begin
			data_phase <= !out.last;
		end
	end

endmodule

//--- verilog/pmu_int.sv
module pmu_int (
	input  logic                clk,
	input  logic                reset,
	input  pmu_pkg::in_byte_t   in_byte,
	output pmu_pkg::out_byte_t  out,
	input  logic                out_ready,
	output logic                scl_low,
	output logic                sda_low,
	input  logic                sda_in
);

	pmu_pkg::pmu_cmd_t  cmd;
	logic               cmd_valid;
	logic               cmd_take;
	pmu_pkg::i2c_req_t  i2c_req;
	logic               req_valid;
	logic               req_done;
	logic               ack_ok;
	logic [7:0]         rd_data;
	logic               timer_run;
	logic               tick;
	pmu_pkg::resp_req_t resp;
	logic               resp_valid;
	logic               resp_take;

	frame_decoder i_frame_decoder (
		.clk(clk), .reset(reset), .in_byte(in_byte),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_take(cmd_take)
	);

	i2c_bit_timer i_i2c_bit_timer (
		.clk(clk), .reset(reset), .run(timer_run), .tick(tick)
	);

	i2c_byte_engine i_i2c_byte_engine (
		.clk(clk), .reset(reset), .req(i2c_req), .req_valid(req_valid),
		.req_done(req_done), .ack_ok(ack_ok), .rd_data(rd_data),
		.scl_low(scl_low), .sda_low(sda_low), .sda_in(sda_in),
		.timer_run(timer_run), .tick(tick)
	);

	pmu_ctrl_fsm i_pmu_ctrl_fsm (
		.clk(clk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
		.cmd_take(cmd_take), .req(i2c_req), .req_valid(req_valid),
		.req_done(req_done), .ack_ok(ack_ok), .rd_data(rd_data),
		.resp(resp), .resp_valid(resp_valid), .resp_take(resp_take)
	);

	ack_frame_gen i_ack_frame_gen (
		.clk(clk), .reset(reset), .resp(resp), .resp_valid(resp_valid),
		.resp_take(resp_take), .out(out), .out_ready(out_ready)
	);

endmodule

//--- testbench/pmu_i2c_model.sv
`include "pmu_defines.svh"

module pmu_i2c_model (
	input  logic scl_low,
	input  logic sda_low,
	output logic sda_in
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0]  regs [0:255];
	logic [15:0] wr_log [$];
	logic        nack_addr;
	int          starts;
	logic        scl;
	logic        prev_scl;
	logic        prev_sda;
	logic        drive_low;
	logic        active;
	logic        tx;
	logic        rd_next;
	int          bit_cnt;
	int          byte_idx;
	logic [7:0]  rx_shift;
	logic [7:0]  tx_shift;
	logic [7:0]  ptr;

	// Nothing stretches the clock, so SCL is only the controller's release
	assign scl = !scl_low;
	assign sda_in = !(sda_low || drive_low);

	initial begin
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'hA5;
		nack_addr = 1'b0;
		starts = 0;
		drive_low = 1'b0;
		active = 1'b0;
		tx = 1'b0;
		rd_next = 1'b0;
		bit_cnt = 0;
		byte_idx = 0;
		ptr = 8'h00;
		prev_scl = 1'b1;
		prev_sda = 1'b1;
	end

	always @(scl or sda_in) begin
		if (scl && prev_scl && prev_sda && !sda_in) begin
			// START condition
			starts++;
			active = 1'b1;
			tx = 1'b0;
			rd_next = 1'b0;
			bit_cnt = 0;
			byte_idx = 0;
			drive_low = 1'b0;
		end else if (scl && prev_scl && !prev_sda && sda_in) begin
			active = 1'b0;
		end else if (active && scl && !prev_scl) begin
			if (bit_cnt < 8)
				rx_shift = {rx_shift[6:0], sda_in};
			bit_cnt++;
		end else if (active && !scl && prev_scl) begin
			if (bit_cnt == 8 && !tx) begin
				if (byte_idx == 0) begin
					// An address miss or a withheld ACK leaves the bus alone until the next START
					if ({rx_shift[7:1], 1'b0} == `PMU_ADDR_WR && !nack_addr) begin
						drive_low = 1'b1;
						rd_next = rx_shift[0];
					end else begin
						active = 1'b0;
					end
				end else begin
					drive_low = 1'b1;
					if (byte_idx == 1) begin
						ptr = rx_shift;
					end else begin
						regs[ptr] = rx_shift;
						wr_log.push_back({ptr, rx_shift});
						ptr++;
					end
				end
				byte_idx++;
			end else if (bit_cnt == 9) begin
				bit_cnt = 0;
				drive_low = 1'b0;
				if (rd_next) begin
					rd_next = 1'b0;
					tx = 1'b1;
					tx_shift = regs[ptr];
					drive_low = !tx_shift[7];
				end else if (tx) begin
					tx = 1'b0;
				end
			end else if (tx) begin
				drive_low = (bit_cnt < 8) && !tx_shift[7 - bit_cnt];
			end
		end
		prev_scl = scl;
		prev_sda = sda_in;
	end

endmodule

//--- testbench/pmu_int_assertions.sv
module pmu_int_assertions (
	input logic               clk,
	input logic               reset,
	input pmu_pkg::out_byte_t out,
	input logic               out_ready,
	input logic               scl_low,
	input logic               sda_low
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	assert property (@(posedge clk) reset |=> !out.valid)
	else begin
		$error("response byte valid during reset");
		failures++;
	end

	// A stalled response byte keeps its data, valid and last
	assert property (@(posedge clk) disable iff (reset) out.valid && !out_ready |=> $stable(out))
	else begin
		$error("response byte changed while stalled");
		failures++;
	end

	assert property (@(posedge clk) $fell(reset) |-> !(scl_low && sda_low))
	else begin
		$error("SCL and SDA both pulled low right after reset");
		failures++;
	end

endmodule

bind pmu_int pmu_int_assertions i_pmu_int_assertions (
	.clk(clk), .reset(reset), .out(out), .out_ready(out_ready),
	.scl_low(scl_low), .sda_low(sda_low)
);

//--- testbench/pmu_int_tb.sv
`include "pmu_defines.svh"

module pmu_int_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESP_TIMEOUT = 5000;
	localparam int QUIET_CYCLES = 400;
	localparam logic [7:0] PARAM_ENABLE = 8'h65;

	logic               clk;
	logic               reset;
	pmu_pkg::in_byte_t  in_byte;
	pmu_pkg::out_byte_t out;
	logic               out_ready;
	logic               scl_low;
	logic               sda_low;
	logic               sda_in;

	logic [31:0] lfsr;
	logic        random_ready;
	int          checks;
	int          errors;
	logic [7:0]  rx_data [$];
	logic        rx_last [$];

	pmu_int i_pmu_int (
		.clk(clk), .reset(reset), .in_byte(in_byte), .out(out), .out_ready(out_ready),
		.scl_low(scl_low), .sda_low(sda_low), .sda_in(sda_in)
	);

	pmu_i2c_model i_pmu_model (.scl_low(scl_low), .sda_low(sda_low), .sda_in(sda_in));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Enable register bits from the MSB down are 100, rail 0, 1, rails 2 and 1, then 1
	function automatic logic [7:0] enable_reg(input logic [2:0] rails);
		return {3'b100, rails[0], 1'b1, rails[2], rails[1], 1'b1};
	endfunction

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("error at %0t ns: %s is 8'h%h, expected 8'h%h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		assert (got == exp) else begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic send_frame(input int n, input logic [7:0] b0, input logic [7:0] b1,
			input logic [7:0] b2, input logic [7:0] b3);
		logic [7:0] bytes [4];
		bytes = '{b0, b1, b2, b3};
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			in_byte.data = bytes[i];
			in_byte.valid = 1'b1;
			in_byte.frame = 1'b1;
		end
		@(negedge clk);
		in_byte = '0;
	endtask

	// Collects one response frame and each byte seen here moves at the next rising edge
	task automatic get_response();
		int   waited;
		logic done;
		waited = 0;
		done = 1'b0;
		rx_data.delete();
		rx_last.delete();
		while (!done && waited < RESP_TIMEOUT) begin
			@(negedge clk);
			out_ready = 1'b1;
			if (random_ready) begin
				lfsr = lfsr_next(lfsr);
				out_ready = lfsr[0];
			end
			if (out.valid && out_ready) begin
				rx_data.push_back(out.data);
				rx_last.push_back(out.last);
				done = out.last;
			end
			waited++;
		end
		if (!done) begin
			$display("Timed out after %0d cycles waiting for a response frame", waited);
			errors++;
		end
	endtask

	task automatic check_frame(input logic nak, input logic has_data, input logic [7:0] data);
		int         n_exp;
		logic [7:0] exp_byte;
		n_exp = (!nak && has_data) ? 2 : 1;
		check_count(rx_data.size(), n_exp, "response length");
		for (int i = 0; i < rx_data.size() && i < n_exp; i++) begin
			exp_byte = (i == 1) ? data : (nak ? `RESP_NAK : `RESP_ACK);
			check_value(rx_data[i], exp_byte, $sformatf("response byte %0d", i));
			check_value({7'd0, rx_last[i]}, {7'd0, i == n_exp - 1},
				$sformatf("last flag of response byte %0d", i));
		end
	endtask

	task automatic finish_test(input string name, input int start_err);
		$display("%s finished with %0d failed checks", name, errors - start_err);
	endtask

	task automatic test_voltage_set();
		int start_err;
		int log_start;
		start_err = errors;
		log_start = i_pmu_model.wr_log.size();
		random_ready = 1'b1;
		send_frame(4, `SET_FRAME_ADDR, `PARAM_VOLT, 8'h01, 8'h13);
		get_response();
		random_ready = 1'b0;
		check_frame(1'b0, 1'b0, 8'h00);
		check_value(i_pmu_model.regs[`SUB_VOLT1], 8'h13 & 8'h1f, "voltage register 1");
		check_value(i_pmu_model.regs[`SUB_SLEW], `SLEW_VALUE, "slew register");
		check_count(i_pmu_model.wr_log.size() - log_start, 2, "register writes");
		if (i_pmu_model.wr_log.size() == log_start + 2) begin
			check_value(i_pmu_model.wr_log[log_start][15:8], `SUB_VOLT1, "first write register");
			check_value(i_pmu_model.wr_log[log_start + 1][15:8], `SUB_SLEW, "second write register");
		end
		finish_test("voltage_set", start_err);
	endtask

	task automatic test_enable_set();
		int start_err;
		start_err = errors;
		send_frame(4, `SET_FRAME_ADDR, PARAM_ENABLE, 8'h00, 8'h01);
		get_response();
		check_frame(1'b0, 1'b0, 8'h00);
		check_value(i_pmu_model.regs[`SUB_ENABLE], enable_reg(3'b001), "enable register");
		send_frame(4, `SET_FRAME_ADDR, PARAM_ENABLE, 8'h02, 8'h01);
		get_response();
		check_frame(1'b0, 1'b0, 8'h00);
		check_value(i_pmu_model.regs[`SUB_ENABLE], enable_reg(3'b101), "enable register");
		finish_test("enable_set", start_err);
	endtask

	task automatic test_query();
		int start_err;
		start_err = errors;
		i_pmu_model.regs[`SUB_VOLT2] = 8'hA7;
		random_ready = 1'b1;
		send_frame(3, `QUERY_FRAME_ADDR, `PARAM_VOLT, 8'h02, 8'h00);
		get_response();
		check_frame(1'b0, 1'b1, 8'hA7);
		// Only bit 1 is set so any other bit would read back as zero
		i_pmu_model.regs[`SUB_ENABLE] = 8'h02;
		send_frame(3, `QUERY_FRAME_ADDR, PARAM_ENABLE, 8'h01, 8'h00);
		get_response();
		random_ready = 1'b0;
		check_frame(1'b0, 1'b1, {7'd0, i_pmu_model.regs[`SUB_ENABLE][1]});
		finish_test("query", start_err);
	endtask

	task automatic test_address_nak();
		int start_err;
		int starts_before;
		start_err = errors;
		starts_before = i_pmu_model.starts;
		i_pmu_model.nack_addr = 1'b1;
		send_frame(4, `SET_FRAME_ADDR, `PARAM_VOLT, 8'h00, 8'h0A);
		get_response();
		i_pmu_model.nack_addr = 1'b0;
		check_frame(1'b1, 1'b0, 8'h00);
		check_count(i_pmu_model.starts - starts_before, 2, "I2C transactions");
		finish_test("address_nak", start_err);
	endtask

	task automatic test_unknown_frame();
		int   start_err;
		int   starts_before;
		logic quiet;
		start_err = errors;
		starts_before = i_pmu_model.starts;
		quiet = 1'b1;
		send_frame(4, 8'h33, `PARAM_VOLT, 8'h01, 8'h13);
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			out_ready = 1'b1;
			if (out.valid || scl_low || sda_low)
				quiet = 1'b0;
		end
		checks++;
		assert (quiet) else begin
			$display("A frame with an unknown address caused I2C or response activity");
			errors++;
		end
		check_count(i_pmu_model.starts, starts_before, "I2C start count");
		finish_test("unknown_frame", start_err);
	endtask

	initial begin
		reset = 1'b1;
		in_byte = '0;
		out_ready = 1'b0;
		random_ready = 1'b0;
		lfsr = 32'h728d_5996;
		checks = 0;
		errors = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_voltage_set();
		test_enable_set();
		test_query();
		test_address_nak();
		test_unknown_frame();
		errors += i_pmu_int.i_pmu_int_assertions.failures;
		$display("%0d checks, %0d failed", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/pmu_pkg.sv
verilog/frame_decoder.sv
verilog/i2c_bit_timer.sv
verilog/i2c_byte_engine.sv
verilog/pmu_ctrl_fsm.sv
verilog/ack_frame_gen.sv
verilog/pmu_int.sv
testbench/pmu_i2c_model.sv
testbench/pmu_int_assertions.sv
testbench/pmu_int_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module pmu_int_tb -f list.f -o pmu_int_sim
./obj_dir/pmu_int_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
